// File: logic/div_pkg.sv
/* Division service shared definitions */

package div_pkg;

    // ====================
    // Data types
    // ====================

    // Operands, quotients and remainders all share the RV32 word width
    typedef logic [31:0] data_word_t;

    // Operation codes follow the low two bits of the M extension funct3
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_uop_t;

    // Byte offset inside the register window of one APB port
    typedef logic [4:0] apb_addr_t;

    // ====================
    // Register map
    // ====================

    localparam apb_addr_t DIVIDEND_OFS = 5'h00;
    localparam apb_addr_t DIVISOR_OFS  = 5'h04;
    // Bits 1:0 select the operation and the write launches the request
    localparam apb_addr_t CTRL_OFS     = 5'h08;
    // Bit 0 busy, bit 1 done, bit 2 divide by zero
    localparam apb_addr_t STATUS_OFS   = 5'h0C;
    // Reading the result clears done
    localparam apb_addr_t RESULT_OFS   = 5'h10;

    // Cycles from the accepting edge to the response pulse of the unit
    localparam int unsigned DIV_LATENCY    = 36;
    // One quotient bit is produced per divider step
    localparam int unsigned DIV_ITERATIONS = 32;

endpackage : div_pkg

// File: logic/div_req_if.sv
/* Division request channel */

interface div_req_if;
    import div_pkg::*;

    // Request side, driven by whoever asks for a division
    logic       req_valid;
    div_uop_t   op;
    data_word_t dividend;
    data_word_t divisor;

    // Server answers, ready is only meaningful while req_valid is high
    logic       req_ready;

    // Response pulse, never back-pressured
    logic       rsp_valid;
    data_word_t result;
    logic       div_by_zero;

    modport requester (
        output req_valid, op, dividend, divisor,
        input  req_ready, rsp_valid, result, div_by_zero
    );

    modport server (
        input  req_valid, op, dividend, divisor,
        output req_ready, rsp_valid, result, div_by_zero
    );

    // Passive view of a whole channel for observers on the arbiter side
    modport arbiter_side (
        input req_valid, op, dividend, divisor,
        input req_ready, rsp_valid, result, div_by_zero
    );

endinterface : div_req_if

// File: logic/non_restoring_divider.sv
/* Unsigned non-restoring divider */

module non_restoring_divider (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  div_pkg::data_word_t dividend_i,
    input  div_pkg::data_word_t divisor_i,
    input  logic                start_i,
    output div_pkg::data_word_t quotient_o,
    output div_pkg::data_word_t remainder_o,
    output logic                div_by_zero_o,
    output logic                valid_o
);
    import div_pkg::*;

    localparam int unsigned W     = $bits(data_word_t);
    // The step counter is sized for the whole unit latency
    localparam int unsigned CNT_W = $clog2(DIV_LATENCY);

    typedef enum logic [1:0] {IDLE, SHIFT, FIX, DONE} div_state_t;

    div_state_t       state_q;
    logic [CNT_W-1:0] step_cnt_q;

    // Partial remainder carries one extra bit used as the sign
    logic [W:0]       part_rem_q;
    data_word_t       quot_q;
    data_word_t       divisor_q;
    logic             dbz_q;

    logic [W:0]       shifted_rem;
    logic [W:0]       next_rem;

    // ====================
    // Iteration datapath
    // ====================

    always_comb begin
        // Shift the next dividend bit into the partial remainder
        shifted_rem = {part_rem_q[W-1:0], quot_q[W-1]};
        // A negative partial remainder adds the divisor back, otherwise subtract
        if (part_rem_q[W]) begin
            next_rem = shifted_rem + {1'b0, divisor_q};
        end else begin
            next_rem = shifted_rem - {1'b0, divisor_q};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            step_cnt_q <= '0;
            dbz_q      <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        part_rem_q <= '0;
                        quot_q     <= dividend_i;
                        divisor_q  <= divisor_i;
                        // Zero divisor is known as soon as the operands arrive
                        dbz_q      <= (divisor_i == '0);
                        step_cnt_q <= '0;
                        state_q    <= SHIFT;
                    end
                end
                SHIFT: begin
                    part_rem_q <= next_rem;
                    // Quotient bit is set whenever the new remainder is not negative
                    quot_q     <= {quot_q[W-2:0], ~next_rem[W]};
                    step_cnt_q <= step_cnt_q + 1'b1;
                    if (step_cnt_q == CNT_W'(DIV_ITERATIONS - 1)) begin
                        state_q <= FIX;
                    end
                end
                FIX: begin
                    // Restore a negative final remainder
                    if (part_rem_q[W]) begin
                        part_rem_q <= part_rem_q + {1'b0, divisor_q};
                    end
                    state_q <= DONE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign quotient_o    = quot_q;
    assign remainder_o   = part_rem_q[W-1:0];
    assign div_by_zero_o = dbz_q;
    // Results are valid for the single cycle spent in DONE
    assign valid_o       = (state_q == DONE);

endmodule : non_restoring_divider

// File: logic/division_unit.sv
/* Signed and unsigned division unit */

module division_unit (
    input  logic      clk_i,
    input  logic      rst_n_i,
    div_req_if.server req
);
    import div_pkg::*;

    localparam int unsigned W     = $bits(data_word_t);
    localparam int unsigned CNT_W = $clog2(DIV_LATENCY);

    logic             idle_q;
    logic [CNT_W-1:0] cycle_cnt_q;
    logic             rsp_valid_q;
    logic             accept;

    // ====================
    // First stage
    // ====================

    // The divider works on magnitudes, so signed operands are converted here
    logic       is_signed;
    logic       dividend_neg;
    logic       divisor_neg;
    data_word_t dividend_mag;
    data_word_t divisor_mag;

    assign accept       = req.req_valid & idle_q;
    assign is_signed    = (req.op == DIV) | (req.op == REM);
    assign dividend_neg = is_signed & req.dividend[W-1];
    assign divisor_neg  = is_signed & req.divisor[W-1];
    assign dividend_mag = dividend_neg ? (~req.dividend + 1'b1) : req.dividend;
    assign divisor_mag  = divisor_neg ? (~req.divisor + 1'b1) : req.divisor;

    data_word_t mag_dividend_q;
    data_word_t mag_divisor_q;
    data_word_t raw_dividend_q;
    logic       neg_quot_q;
    logic       neg_rem_q;
    div_uop_t   op_q;
    logic       start_q;

    // Operands and sign-fix flags stay put until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mag_dividend_q <= dividend_mag;
            mag_divisor_q  <= divisor_mag;
            raw_dividend_q <= req.dividend;
            neg_quot_q     <= dividend_neg ^ divisor_neg;
            neg_rem_q      <= dividend_neg;
            op_q           <= req.op;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
        end
    end

    // ====================
    // Division stage
    // ====================

    data_word_t quotient;
    data_word_t remainder;
    logic       dbz;
    logic       div_valid;

    non_restoring_divider i_divider (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dividend_i    (mag_dividend_q),
        .divisor_i     (mag_divisor_q),
        .start_i       (start_q),
        .quotient_o    (quotient),
        .remainder_o   (remainder),
        .div_by_zero_o (dbz),
        .valid_o       (div_valid)
    );

    // ====================
    // Last stage
    // ====================

    data_word_t fixed_quot;
    data_word_t fixed_rem;
    data_word_t result_q;
    logic       dbz_q;

    // Quotient is negated on differing signs, remainder takes the dividend sign
    // and a zero divisor yields all ones and the untouched dividend
    assign fixed_quot = dbz ? '1 : (neg_quot_q ? (~quotient + 1'b1) : quotient);
    assign fixed_rem  = dbz ? raw_dividend_q
                            : (neg_rem_q ? (~remainder + 1'b1) : remainder);

    always_ff @(posedge clk_i) begin
        if (div_valid) begin
            result_q <= ((op_q == DIV) || (op_q == DIVU)) ? fixed_quot : fixed_rem;
            dbz_q    <= dbz;
        end
    end

    // Cycle counter pins the response to exactly DIV_LATENCY edges after accept
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idle_q      <= 1'b1;
            rsp_valid_q <= 1'b0;
            cycle_cnt_q <= '0;
        end else begin
            rsp_valid_q <= 1'b0;
            if (accept) begin
                idle_q      <= 1'b0;
                cycle_cnt_q <= CNT_W'(DIV_LATENCY - 1);
            end else if (!idle_q) begin
                if (cycle_cnt_q == '0) begin
                    idle_q      <= 1'b1;
                    rsp_valid_q <= 1'b1;
                end else begin
                    cycle_cnt_q <= cycle_cnt_q - 1'b1;
                end
            end
        end
    end

    assign req.req_ready   = idle_q;
    assign req.rsp_valid   = rsp_valid_q;
    assign req.result      = result_q;
    assign req.div_by_zero = dbz_q;

endmodule : division_unit

// File: logic/div_arbiter.sv
/* Round-robin division arbiter */

module div_arbiter (
    input  logic         clk_i,
    input  logic         rst_n_i,
    div_req_if.server    req0,
    div_req_if.server    req1,
    div_req_if.requester unit
);

    typedef enum logic {IDLE, BUSY} arb_state_t;

    arb_state_t state_q;
    // Port that owns the division in flight
    logic       owner_q;
    // Port served most recently, it loses the next tie
    logic       last_q;

    logic       grant;
    logic       sel;
    logic       accept;

    // ====================
    // Grant selection
    // ====================

    always_comb begin
        if (req0.req_valid && req1.req_valid) begin
            grant = ~last_q;
        end else begin
            grant = req1.req_valid;
        end
    end

    // While busy the mux stays on the owner
    assign sel = (state_q == IDLE) ? grant : owner_q;

    assign unit.req_valid = (state_q == IDLE)
                          & (sel ? req1.req_valid : req0.req_valid);
    assign unit.op        = sel ? req1.op : req0.op;
    assign unit.dividend  = sel ? req1.dividend : req0.dividend;
    assign unit.divisor   = sel ? req1.divisor : req0.divisor;

    assign req0.req_ready = (state_q == IDLE) & ~grant & unit.req_ready;
    assign req1.req_ready = (state_q == IDLE) & grant & unit.req_ready;

    assign accept = unit.req_valid & unit.req_ready;

    // ====================
    // Ownership FSM
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            owner_q <= 1'b0;
            last_q  <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        owner_q <= grant;
                        last_q  <= grant;
                        state_q <= BUSY;
                    end
                end
                default: begin
                    // Grant is released only once the result is back
                    if (unit.rsp_valid) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    // Result data is shared, only the owner sees the valid pulse
    assign req0.rsp_valid   = unit.rsp_valid & (state_q == BUSY) & ~owner_q;
    assign req1.rsp_valid   = unit.rsp_valid & (state_q == BUSY) & owner_q;
    assign req0.result      = unit.result;
    assign req1.result      = unit.result;
    assign req0.div_by_zero = unit.div_by_zero;
    assign req1.div_by_zero = unit.div_by_zero;

endmodule : div_arbiter

// File: logic/apb_div_port.sv
/* APB division register block */

module apb_div_port (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  div_pkg::apb_addr_t  paddr_i,
    input  div_pkg::data_word_t pwdata_i,
    output div_pkg::data_word_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    div_req_if.requester        req
);
    import div_pkg::*;

    data_word_t dividend_q;
    data_word_t divisor_q;
    data_word_t result_q;
    div_uop_t   op_q;
    logic       req_valid_q;
    logic       busy_q;
    logic       done_q;
    logic       dbz_q;

    logic       access;
    logic       addr_hit;
    logic       wr_en;
    logic       rd_result;

    // ====================
    // Decode
    // ====================

    // Transfers complete in the access phase, there are no wait states
    assign access   = psel_i & penable_i;
    assign addr_hit = (paddr_i == DIVIDEND_OFS) | (paddr_i == DIVISOR_OFS)
                    | (paddr_i == CTRL_OFS) | (paddr_i == STATUS_OFS)
                    | (paddr_i == RESULT_OFS);

    // Writes are dropped while a request is pending
    assign wr_en     = access & pwrite_i & addr_hit & ~busy_q;
    assign rd_result = access & ~pwrite_i & (paddr_i == RESULT_OFS);

    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~addr_hit | (pwrite_i & busy_q));

    always_comb begin
        case (paddr_i)
            DIVIDEND_OFS: prdata_o = dividend_q;
            DIVISOR_OFS:  prdata_o = divisor_q;
            CTRL_OFS:     prdata_o = {30'b0, op_q};
            STATUS_OFS:   prdata_o = {29'b0, dbz_q, done_q, busy_q};
            RESULT_OFS:   prdata_o = result_q;
            default:      prdata_o = '0;
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk_i) begin
        if (wr_en && (paddr_i == DIVIDEND_OFS)) begin
            dividend_q <= pwdata_i;
        end
        if (wr_en && (paddr_i == DIVISOR_OFS)) begin
            divisor_q <= pwdata_i;
        end
        if (req.rsp_valid) begin
            result_q <= req.result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_q        <= DIV;
            req_valid_q <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            dbz_q       <= 1'b0;
        end else begin
            // A CTRL write launches the request and raises busy
            if (wr_en && (paddr_i == CTRL_OFS)) begin
                op_q        <= div_uop_t'(pwdata_i[1:0]);
                req_valid_q <= 1'b1;
                busy_q      <= 1'b1;
                done_q      <= 1'b0;
            end
            // Request leaves once the arbiter hands it to the unit
            if (req_valid_q && req.req_ready) begin
                req_valid_q <= 1'b0;
            end
            if (rd_result) begin
                done_q <= 1'b0;
            end
            // The response wins over a clearing read in the same cycle
            if (req.rsp_valid) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
                dbz_q  <= req.div_by_zero;
            end
        end
    end

    assign req.req_valid = req_valid_q;
    assign req.op        = op_q;
    assign req.dividend  = dividend_q;
    assign req.divisor   = divisor_q;

endmodule : apb_div_port

// File: logic/div_subsystem_top.sv
/* Dual-port division subsystem */

module div_subsystem_top (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Hart 0 APB completer
    input  logic                psel0_i,
    input  logic                penable0_i,
    input  logic                pwrite0_i,
    input  div_pkg::apb_addr_t  paddr0_i,
    input  div_pkg::data_word_t pwdata0_i,
    output div_pkg::data_word_t prdata0_o,
    output logic                pready0_o,
    output logic                pslverr0_o,

    // Hart 1 APB completer
    input  logic                psel1_i,
    input  logic                penable1_i,
    input  logic                pwrite1_i,
    input  div_pkg::apb_addr_t  paddr1_i,
    input  div_pkg::data_word_t pwdata1_i,
    output div_pkg::data_word_t prdata1_o,
    output logic                pready1_o,
    output logic                pslverr1_o
);

    // One channel per hart plus the shared channel into the unit
    div_req_if port0_req ();
    div_req_if port1_req ();
    div_req_if unit_req ();

    apb_div_port i_port0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel0_i),
        .penable_i (penable0_i),
        .pwrite_i  (pwrite0_i),
        .paddr_i   (paddr0_i),
        .pwdata_i  (pwdata0_i),
        .prdata_o  (prdata0_o),
        .pready_o  (pready0_o),
        .pslverr_o (pslverr0_o),
        .req       (port0_req.requester)
    );

    apb_div_port i_port1 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel1_i),
        .penable_i (penable1_i),
        .pwrite_i  (pwrite1_i),
        .paddr_i   (paddr1_i),
        .pwdata_i  (pwdata1_i),
        .prdata_o  (prdata1_o),
        .pready_o  (pready1_o),
        .pslverr_o (pslverr1_o),
        .req       (port1_req.requester)
    );

    div_arbiter i_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req0    (port0_req.server),
        .req1    (port1_req.server),
        .unit    (unit_req.requester)
    );

    division_unit i_division_unit (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req     (unit_req.server)
    );

endmodule : div_subsystem_top

// File: tests/tb_div_subsystem.sv
/* Division subsystem testbench */

module tb_div_subsystem;
    import div_pkg::*;

    localparam int        NUM_RANDOM   = 200;
    // Directed, error and reset cases come on top of the random run
    localparam int        NUM_OPS      = NUM_RANDOM + 30;
    localparam int        MAX_POLLS    = 200;
    localparam time       TIMEOUT      = NUM_OPS * (DIV_LATENCY + 20) * 2 * 8 + 5000;
    localparam apb_addr_t UNMAPPED_OFS = 5'h14;

    // One finished operation waiting for the compare process
    typedef struct {
        int         hart;
        div_uop_t   op;
        data_word_t a;
        data_word_t b;
        data_word_t got;
    } done_op_t;

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    // Index 0 drives hart 0 and index 1 drives hart 1
    logic       psel [2];
    logic       penable [2];
    logic       pwrite [2];
    apb_addr_t  paddr [2];
    data_word_t pwdata [2];
    data_word_t prdata [2];
    logic       pready [2];
    logic       pslverr [2];

    int         errors;
    int         checks;
    done_op_t   done_ops [$];
    done_op_t   cmp_item;

    div_uop_t   rnd_op [NUM_RANDOM];
    data_word_t rnd_a [NUM_RANDOM];
    data_word_t rnd_b [NUM_RANDOM];

    div_subsystem_top i_div_subsystem_top (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .psel0_i    (psel[0]),
        .penable0_i (penable[0]),
        .pwrite0_i  (pwrite[0]),
        .paddr0_i   (paddr[0]),
        .pwdata0_i  (pwdata[0]),
        .prdata0_o  (prdata[0]),
        .pready0_o  (pready[0]),
        .pslverr0_o (pslverr[0]),
        .psel1_i    (psel[1]),
        .penable1_i (penable[1]),
        .pwrite1_i  (pwrite[1]),
        .paddr1_i   (paddr[1]),
        .pwdata1_i  (pwdata[1]),
        .prdata1_o  (prdata[1]),
        .pready1_o  (pready[1]),
        .pslverr1_o (pslverr[1])
    );

    always #4 clk_i = ~clk_i;

    // ====================
    // Reference and checks
    // ====================

    // RISC-V M extension semantics with division truncating toward zero
    function automatic data_word_t ref_div(input div_uop_t op, input data_word_t a,
                                           input data_word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sres;
        logic               overflow;
        sa       = a;
        sb       = b;
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (b == '0) begin
            return ((op == DIV) || (op == DIVU)) ? 32'hffff_ffff : a;
        end
        case (op)
            DIV: begin
                // The one signed quotient that does not fit wraps back to the dividend
                if (overflow) begin
                    sres = sa;
                end else begin
                    sres = sa / sb;
                end
            end
            REM: begin
                if (overflow) begin
                    sres = '0;
                end else begin
                    sres = sa % sb;
                end
            end
            DIVU:    sres = a / b;
            default: sres = a % b;
        endcase
        return sres;
    endfunction

    task automatic check_value(input string name, input data_word_t got,
                               input data_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Every finished operation is checked against the reference
    always @(posedge clk_i) begin
        while (done_ops.size() > 0) begin
            cmp_item = done_ops.pop_front();
            check_value($sformatf("prdata%0d_o", cmp_item.hart), cmp_item.got,
                        ref_div(cmp_item.op, cmp_item.a, cmp_item.b));
        end
    end

    // ====================
    // APB and sequences
    // ====================

    // Setup phase, access phase, then the bus goes idle again
    task automatic apb_write(input int hart, input apb_addr_t addr, input data_word_t data,
                             output logic err);
        @(posedge clk_i);
        #1;
        psel[hart]    = 1'b1;
        penable[hart] = 1'b0;
        pwrite[hart]  = 1'b1;
        paddr[hart]   = addr;
        pwdata[hart]  = data;
        @(posedge clk_i);
        #1;
        penable[hart] = 1'b1;
        // Completer outputs are settled in the middle of the access cycle
        @(negedge clk_i);
        err = pslverr[hart];
        check_value($sformatf("pready%0d_o", hart), 32'(pready[hart]), 32'd1);
        @(posedge clk_i);
        #1;
        psel[hart]    = 1'b0;
        penable[hart] = 1'b0;
    endtask

    task automatic apb_read(input int hart, input apb_addr_t addr, output data_word_t data,
                            output logic err);
        @(posedge clk_i);
        #1;
        psel[hart]    = 1'b1;
        penable[hart] = 1'b0;
        pwrite[hart]  = 1'b0;
        paddr[hart]   = addr;
        @(posedge clk_i);
        #1;
        penable[hart] = 1'b1;
        @(negedge clk_i);
        data = prdata[hart];
        err  = pslverr[hart];
        check_value($sformatf("pready%0d_o", hart), 32'(pready[hart]), 32'd1);
        @(posedge clk_i);
        #1;
        psel[hart]    = 1'b0;
        penable[hart] = 1'b0;
    endtask

    task automatic issue_op(input int hart, input div_uop_t op, input data_word_t a,
                            input data_word_t b);
        logic err;
        apb_write(hart, DIVIDEND_OFS, a, err);
        check_value($sformatf("pslverr%0d_o", hart), 32'(err), 32'd0);
        apb_write(hart, DIVISOR_OFS, b, err);
        check_value($sformatf("pslverr%0d_o", hart), 32'(err), 32'd0);
        // The CTRL write starts the request
        apb_write(hart, CTRL_OFS, 32'(op), err);
        check_value($sformatf("pslverr%0d_o", hart), 32'(err), 32'd0);
    endtask

    // Polls STATUS until done shows up, the poll count bounds the wait
    task automatic wait_done(input int hart, output data_word_t status);
        logic err;
        int   polls;
        polls  = 0;
        status = '0;
        while ((status[1] !== 1'b1) && (polls < MAX_POLLS)) begin
            apb_read(hart, STATUS_OFS, status, err);
            polls++;
        end
        if (status[1] !== 1'b1) begin
            errors++;
            $display("ERROR t=%0t hart %0d never reported done in STATUS", $time, hart);
        end
    endtask

    task automatic run_op(input int hart, input div_uop_t op, input data_word_t a,
                          input data_word_t b, output data_word_t status);
        data_word_t result;
        logic       err;
        issue_op(hart, op, a, b);
        wait_done(hart, status);
        apb_read(hart, RESULT_OFS, result, err);
        done_ops.push_back('{hart, op, a, b, result});
    endtask

    // Each hart takes every second entry of the random table
    task automatic random_stream(input int hart);
        data_word_t status;
        for (int i = hart; i < NUM_RANDOM; i += 2) begin
            run_op(hart, rnd_op[i], rnd_a[i], rnd_b[i], status);
        end
    endtask

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        data_word_t status;
        data_word_t rdata;
        data_word_t op_a;
        data_word_t op_b;
        logic       err;

        errors  = 0;
        checks  = 0;
        rst_n_i = 1'b0;
        for (int h = 0; h < 2; h++) begin
            psel[h]    = 1'b0;
            penable[h] = 1'b0;
            pwrite[h]  = 1'b0;
            paddr[h]   = '0;
            pwdata[h]  = '0;
        end
        void'($urandom(32'hd9ba_2c97));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_op[i] = div_uop_t'($urandom_range(3, 0));
            rnd_a[i]  = $urandom;
            rnd_b[i]  = $urandom;
            // Small divisors, zero among them, turn up every few operations
            if ($urandom_range(3, 0) == 0) begin
                rnd_b[i] = $urandom_range(15, 0);
            end
        end
        apply_reset();

        // Unsigned cases: plain, dividend below divisor, zero remainder, full width
        run_op(0, DIVU, 32'd100, 32'd7, status);
        run_op(0, REMU, 32'd100, 32'd7, status);
        run_op(0, DIVU, 32'd5, 32'd9, status);
        run_op(0, REMU, 32'd5, 32'd9, status);
        run_op(0, REMU, 32'd144, 32'd12, status);
        run_op(0, DIVU, 32'hffff_ffff, 32'd3, status);
        // All four sign combinations for signed quotient and remainder
        for (int s = 0; s < 4; s++) begin
            op_a = s[0] ? -32'sd100 : 32'sd100;
            op_b = s[1] ? -32'sd7 : 32'sd7;
            run_op(0, DIV, op_a, op_b, status);
            run_op(0, REM, op_a, op_b, status);
        end
        run_op(0, REM, -32'sd5, 32'sd9, status);
        run_op(0, DIV, -32'sd144, 32'sd12, status);

        // Divide by zero on every operation flags STATUS bit 2
        for (int k = 0; k < 4; k++) begin
            run_op(k % 2, div_uop_t'(k), 32'h8765_4321, 32'd0, status);
            check_value($sformatf("STATUS[2] hart %0d", k % 2), 32'(status[2]), 32'd1);
        end
        // Signed overflow gives the reference values with no flag
        run_op(0, DIV, 32'h8000_0000, 32'hffff_ffff, status);
        check_value("STATUS[2] hart 0", 32'(status[2]), 32'd0);
        run_op(0, REM, 32'h8000_0000, 32'hffff_ffff, status);
        check_value("STATUS[2] hart 0", 32'(status[2]), 32'd0);

        // Both harts issue at once so their requests contend for the unit
        fork
            random_stream(0);
            random_stream(1);
        join

        // Hart 1 holds the unit, so hart 0 stays busy while it waits for the grant
        issue_op(1, DIV, -32'sd999, 32'sd10);
        issue_op(0, DIVU, 32'd1000, 32'd33);
        apb_write(0, DIVIDEND_OFS, 32'd5, err);
        check_value("pslverr0_o", 32'(err), 32'd1);
        wait_done(1, status);
        apb_read(1, RESULT_OFS, rdata, err);
        done_ops.push_back('{1, DIV, -32'sd999, 32'sd10, rdata});
        wait_done(0, status);
        apb_read(0, RESULT_OFS, rdata, err);
        done_ops.push_back('{0, DIVU, 32'd1000, 32'd33, rdata});

        // Unmapped offsets are rejected both ways
        apb_write(1, UNMAPPED_OFS, 32'h1234_5678, err);
        check_value("pslverr1_o", 32'(err), 32'd1);
        apb_read(1, UNMAPPED_OFS, rdata, err);
        check_value("pslverr1_o", 32'(err), 32'd1);

        // The RESULT read inside run_op has to clear done but keep the flag
        run_op(1, REM, 32'hdead_beef, 32'd0, status);
        apb_read(1, STATUS_OFS, status, err);
        check_value("STATUS[1] hart 1", 32'(status[1]), 32'd0);
        check_value("STATUS[2] hart 1", 32'(status[2]), 32'd1);

        // Hart 0 is left busy so that reset has a live status to clear on each port
        issue_op(0, DIVU, 32'd77, 32'd0);

        // Reset clears every status bit on both ports
        @(posedge clk_i);
        #1;
        apply_reset();
        for (int h = 0; h < 2; h++) begin
            apb_read(h, STATUS_OFS, status, err);
            check_value($sformatf("STATUS hart %0d", h), status, 32'd0);
        end

        // Let the compare process drain what is left
        repeat (2) @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Bound taken from the operation count with a wide per-operation allowance
    initial begin
        #(TIMEOUT);
        $display("Timeout at t=%0t, the tests did not complete in time", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule : tb_div_subsystem

// File: list.f
logic/div_pkg.sv
logic/div_req_if.sv
logic/non_restoring_divider.sv
logic/division_unit.sv
logic/div_arbiter.sv
logic/apb_div_port.sv
logic/div_subsystem_top.sv
tests/tb_div_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the division subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_div_subsystem

verilator --binary --timing -Wno-fatal -f list.f --top-module "$TOP" \
    --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

echo "Testbench reported no failure"
exit 0
